// ==== Makefile ====
SIM     ?= verilator
TOP     ?= tb_lsu
FLIST   ?= verilog.f
BUILD   ?= obj_dir
LOG     ?= sim.log
VFLAGS  ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "variables: SIM TOP FLIST BUILD LOG VFLAGS"

test:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== design/load_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_align #(
	parameter int ADDR_WIDTH = 32
) (
	input  lsu_pkg::mem_op_e               op,
	input  wire [ADDR_WIDTH-1:0]           addr,
	input  wire                            second_beat,
	input  wire [lsu_pkg::BEAT_WIDTH-1:0]  first_beat,
	input  wire [lsu_pkg::BEAT_WIDTH-1:0]  last_beat,
	output logic                           need_second,
	output logic [ADDR_WIDTH-1:0]          araddr,
	output logic [31:0]                    load_result
);

	localparam int OFS         = lsu_pkg::BEAT_OFFSET_BITS;
	localparam int SPILL_WIDTH = 24;
	localparam int JOIN_WIDTH  = lsu_pkg::BEAT_WIDTH + SPILL_WIDTH;

	logic [OFS-1:0]        offset;
	logic [3:0]            size_mask;
	logic [11:0]           byte_span;
	logic [JOIN_WIDTH-1:0] joined;
	logic [JOIN_WIDTH-1:0] shifted;
	logic [31:0]           word;
	logic [ADDR_WIDTH-1:0] low_addr;

	assign offset = addr[OFS-1:0];

	always_comb begin
		case (op)
			lsu_pkg::MEM_LW:                  size_mask = 4'b1111;
			lsu_pkg::MEM_LH, lsu_pkg::MEM_LHU: size_mask = 4'b0011;
			lsu_pkg::MEM_LB, lsu_pkg::MEM_LBU: size_mask = 4'b0001;
			default:                          size_mask = 4'b0000;
		endcase
	end

	// any byte past lane 7 needs the next beat
	assign byte_span   = {8'b0, size_mask} << offset;
	assign need_second = |byte_span[11:lsu_pkg::BEAT_BYTES];

	// at most three bytes come from the second beat
	assign joined  = {last_beat[SPILL_WIDTH-1:0], need_second ? first_beat : last_beat};
	assign shifted = joined >> {offset, 3'b000};
	assign word    = shifted[31:0];

	always_comb begin
		case (op)
			lsu_pkg::MEM_LH:  load_result = {{16{word[15]}}, word[15:0]};
			lsu_pkg::MEM_LHU: load_result = {16'b0, word[15:0]};
			lsu_pkg::MEM_LB:  load_result = {{24{word[7]}}, word[7:0]};
			lsu_pkg::MEM_LBU: load_result = {24'b0, word[7:0]};
			default:          load_result = word;
		endcase
	end

	assign low_addr = {addr[ADDR_WIDTH-1:OFS], {OFS{1'b0}}};
	assign araddr   = second_beat ? low_addr + ADDR_WIDTH'(lsu_pkg::BEAT_BYTES) : low_addr;

endmodule

`default_nettype wire

// ==== design/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

	// byte address width when the top level keeps its default
	localparam int ADDR_WIDTH_DEFAULT = 32;

	// one memory data beat
	localparam int BEAT_WIDTH = 64;
	localparam int BEAT_BYTES = BEAT_WIDTH / 8;

	// address bits that pick a byte inside a beat
	localparam int BEAT_OFFSET_BITS = $clog2(BEAT_BYTES);

	// one strobe bit per beat byte
	localparam int STRB_WIDTH = BEAT_BYTES;

	// loads take the low codes, stores the high ones
	typedef enum logic [3:0] {
		MEM_LW  = 4'h0,
		MEM_LH  = 4'h1,
		MEM_LHU = 4'h2,
		MEM_LB  = 4'h3,
		MEM_LBU = 4'h4,
		MEM_SW  = 4'h8,
		MEM_SH  = 4'h9,
		MEM_SB  = 4'ha
	} mem_op_e;

endpackage

`default_nettype wire

// ==== design/lsu_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_stage #(
	parameter int ADDR_WIDTH     = 32,
	parameter int REG_ADDR_WIDTH = 5
) (
	input  wire                      clock,
	input  wire                      reset,
	input  wire                      in_valid,
	input  lsu_pkg::mem_op_e         in_op,
	input  wire [ADDR_WIDTH-1:0]     in_base,
	input  wire [ADDR_WIDTH-1:0]     in_offset,
	input  wire [31:0]               in_store_data,
	input  wire [REG_ADDR_WIDTH-1:0] in_rd,
	input  wire                      rd_done,
	input  wire                      wr_done,
	input  wire [31:0]               load_result,
	output logic                     in_allowin,
	output lsu_pkg::mem_op_e         op,
	output logic [ADDR_WIDTH-1:0]    addr,
	output logic [31:0]              store_data,
	output logic                     read_start,
	output logic                     write_start,
	output logic                     retire,
	output logic                     regfile_wen,
	output logic [REG_ADDR_WIDTH-1:0] regfile_waddr,
	output logic [31:0]              regfile_wdata
);

	logic stage_valid;
	logic is_store;
	logic is_load;
	logic ready_go;
	logic accept;

	assign accept = in_valid && in_allowin;

	// one instruction held at a time
	always_ff @(posedge clock) begin
		if (reset) begin
			stage_valid <= 1'b0;
		end else if (in_allowin) begin
			stage_valid <= in_valid;
		end
	end

	// effective address formed on the way in
	always_ff @(posedge clock) begin
		if (accept) begin
			op            <= in_op;
			addr          <= in_base + in_offset;
			store_data    <= in_store_data;
			regfile_waddr <= in_rd;
		end
	end

	assign is_store = (op == lsu_pkg::MEM_SW) || (op == lsu_pkg::MEM_SH) ||
		(op == lsu_pkg::MEM_SB);
	assign is_load  = !is_store;

	// the matching controller's done pulse ends the instruction
	assign ready_go   = is_store ? wr_done : rd_done;
	assign in_allowin = !stage_valid || ready_go;
	assign retire     = stage_valid && ready_go;

	// start drops in the done cycle so the idle FSM does not restart
	assign read_start  = stage_valid && is_load && !rd_done;
	assign write_start = stage_valid && is_store && !wr_done;

	assign regfile_wen   = retire && is_load;
	assign regfile_wdata = load_result;

endmodule

`default_nettype wire

// ==== design/lsu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_top #(
	parameter int ADDR_WIDTH     = lsu_pkg::ADDR_WIDTH_DEFAULT,
	parameter int REG_ADDR_WIDTH = 5
) (
	input  wire                               clock,
	input  wire                               reset,
	// instruction side
	input  wire                               in_valid,
	input  lsu_pkg::mem_op_e                  in_op,
	input  wire [ADDR_WIDTH-1:0]              in_base,
	input  wire [ADDR_WIDTH-1:0]              in_offset,
	input  wire [31:0]                        in_store_data,
	input  wire [REG_ADDR_WIDTH-1:0]          in_rd,
	output wire                               in_allowin,
	// writeback
	output wire                               retire,
	output wire                               regfile_wen,
	output wire [REG_ADDR_WIDTH-1:0]          regfile_waddr,
	output wire [31:0]                        regfile_wdata,
	// read address and data
	output wire                               mem_arvalid,
	output wire [ADDR_WIDTH-1:0]              mem_araddr,
	input  wire                               mem_arready,
	input  wire                               mem_rvalid,
	input  wire [lsu_pkg::BEAT_WIDTH-1:0]     mem_rdata,
	output wire                               mem_rready,
	// write address, data and response
	output wire                               mem_awvalid,
	output wire [ADDR_WIDTH-1:0]              mem_awaddr,
	input  wire                               mem_awready,
	output wire                               mem_wvalid,
	output wire [lsu_pkg::BEAT_WIDTH-1:0]     mem_wdata,
	output wire [lsu_pkg::STRB_WIDTH-1:0]     mem_wstrb,
	output wire                               mem_wlast,
	input  wire                               mem_wready,
	input  wire                               mem_bvalid,
	output wire                               mem_bready
);

	lsu_pkg::mem_op_e op;
	wire [ADDR_WIDTH-1:0]          addr;
	wire [31:0]                    store_data;
	wire                           read_start;
	wire                           write_start;
	wire                           rd_done;
	wire                           wr_done;
	wire                           rd_need_second;
	wire                           wr_need_second;
	wire                           rd_second_beat;
	wire                           wr_second_beat;
	wire [ADDR_WIDTH-1:0]          araddr;
	wire [ADDR_WIDTH-1:0]          awaddr;
	wire [lsu_pkg::BEAT_WIDTH-1:0] wdata;
	wire [lsu_pkg::STRB_WIDTH-1:0] wstrb;
	wire [lsu_pkg::BEAT_WIDTH-1:0] first_beat;
	wire [lsu_pkg::BEAT_WIDTH-1:0] last_beat;
	wire [31:0]                    load_result;

	lsu_stage #(
		.ADDR_WIDTH     (ADDR_WIDTH),
		.REG_ADDR_WIDTH (REG_ADDR_WIDTH)
	) u_stage (
		.clock         (clock),
		.reset         (reset),
		.in_valid      (in_valid),
		.in_op         (in_op),
		.in_base       (in_base),
		.in_offset     (in_offset),
		.in_store_data (in_store_data),
		.in_rd         (in_rd),
		.rd_done       (rd_done),
		.wr_done       (wr_done),
		.load_result   (load_result),
		.in_allowin    (in_allowin),
		.op            (op),
		.addr          (addr),
		.store_data    (store_data),
		.read_start    (read_start),
		.write_start   (write_start),
		.retire        (retire),
		.regfile_wen   (regfile_wen),
		.regfile_waddr (regfile_waddr),
		.regfile_wdata (regfile_wdata)
	);

	store_align #(.ADDR_WIDTH(ADDR_WIDTH)) u_store_align (
		.op          (op),
		.addr        (addr),
		.store_data  (store_data),
		.second_beat (wr_second_beat),
		.need_second (wr_need_second),
		.awaddr      (awaddr),
		.wdata       (wdata),
		.wstrb       (wstrb)
	);

	load_align #(.ADDR_WIDTH(ADDR_WIDTH)) u_load_align (
		.op          (op),
		.addr        (addr),
		.second_beat (rd_second_beat),
		.first_beat  (first_beat),
		.last_beat   (last_beat),
		.need_second (rd_need_second),
		.araddr      (araddr),
		.load_result (load_result)
	);

	mem_read_ctrl #(.ADDR_WIDTH(ADDR_WIDTH)) u_read_ctrl (
		.clock       (clock),
		.reset       (reset),
		.start       (read_start),
		.need_second (rd_need_second),
		.araddr      (araddr),
		.mem_arready (mem_arready),
		.mem_rvalid  (mem_rvalid),
		.mem_rdata   (mem_rdata),
		.mem_arvalid (mem_arvalid),
		.mem_araddr  (mem_araddr),
		.mem_rready  (mem_rready),
		.done        (rd_done),
		.second_beat (rd_second_beat),
		.first_beat  (first_beat),
		.last_beat   (last_beat)
	);

	mem_write_ctrl #(.ADDR_WIDTH(ADDR_WIDTH)) u_write_ctrl (
		.clock       (clock),
		.reset       (reset),
		.start       (write_start),
		.need_second (wr_need_second),
		.awaddr      (awaddr),
		.wdata       (wdata),
		.wstrb       (wstrb),
		.mem_awready (mem_awready),
		.mem_wready  (mem_wready),
		.mem_bvalid  (mem_bvalid),
		.mem_awvalid (mem_awvalid),
		.mem_awaddr  (mem_awaddr),
		.mem_wvalid  (mem_wvalid),
		.mem_wdata   (mem_wdata),
		.mem_wstrb   (mem_wstrb),
		.mem_wlast   (mem_wlast),
		.mem_bready  (mem_bready),
		.done        (wr_done),
		.second_beat (wr_second_beat)
	);

endmodule

`default_nettype wire

// ==== design/mem_read_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_read_ctrl #(
	parameter int ADDR_WIDTH = 32
) (
	input  wire                           clock,
	input  wire                           reset,
	input  wire                           start,
	input  wire                           need_second,
	input  wire [ADDR_WIDTH-1:0]          araddr,
	input  wire                           mem_arready,
	input  wire                           mem_rvalid,
	input  wire [lsu_pkg::BEAT_WIDTH-1:0] mem_rdata,
	output logic                          mem_arvalid,
	output logic [ADDR_WIDTH-1:0]         mem_araddr,
	output logic                          mem_rready,
	output logic                          done,
	output logic                          second_beat,
	output logic [lsu_pkg::BEAT_WIDTH-1:0] first_beat,
	output logic [lsu_pkg::BEAT_WIDTH-1:0] last_beat
);

	localparam logic [1:0] R_IDLE    = 2'd0;
	localparam logic [1:0] R_WAIT_AR = 2'd1;
	localparam logic [1:0] R_WAIT_R  = 2'd2;
	localparam logic [1:0] R_IDLE2   = 2'd3;

	logic [1:0] state;
	logic       final_beat;
	logic       issue;

	assign final_beat = !need_second || second_beat;
	assign issue      = (state == R_IDLE && start) || (state == R_IDLE2);

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= R_IDLE;
			mem_arvalid <= 1'b0;
			mem_rready  <= 1'b0;
			done        <= 1'b0;
			second_beat <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				R_IDLE, R_IDLE2: begin
					if (issue) begin
						mem_arvalid <= 1'b1;
						state       <= R_WAIT_AR;
					end
				end
				R_WAIT_AR: begin
					if (mem_arready) begin
						mem_arvalid <= 1'b0;
						mem_rready  <= 1'b1;
						state       <= R_WAIT_R;
					end
				end
				default: begin
					if (mem_rvalid) begin
						mem_rready <= 1'b0;
						if (final_beat) begin
							done        <= 1'b1;
							second_beat <= 1'b0;
							state       <= R_IDLE;
						end else begin
							second_beat <= 1'b1;
							state       <= R_IDLE2;
						end
					end
				end
			endcase
		end
	end

	// address held with arvalid, beats kept for the load extractor
	always_ff @(posedge clock) begin
		if (issue) begin
			mem_araddr <= araddr;
		end
		if (mem_rvalid && mem_rready) begin
			last_beat <= mem_rdata;
			if (!final_beat) begin
				first_beat <= mem_rdata;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/mem_write_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_write_ctrl #(
	parameter int ADDR_WIDTH = 32
) (
	input  wire                           clock,
	input  wire                           reset,
	input  wire                           start,
	input  wire                           need_second,
	input  wire [ADDR_WIDTH-1:0]          awaddr,
	input  wire [lsu_pkg::BEAT_WIDTH-1:0] wdata,
	input  wire [lsu_pkg::STRB_WIDTH-1:0] wstrb,
	input  wire                           mem_awready,
	input  wire                           mem_wready,
	input  wire                           mem_bvalid,
	output logic                          mem_awvalid,
	output logic [ADDR_WIDTH-1:0]         mem_awaddr,
	output logic                          mem_wvalid,
	output logic [lsu_pkg::BEAT_WIDTH-1:0] mem_wdata,
	output logic [lsu_pkg::STRB_WIDTH-1:0] mem_wstrb,
	output logic                          mem_wlast,
	output logic                          mem_bready,
	output logic                          done,
	output logic                          second_beat
);

	localparam logic [2:0] W_IDLE    = 3'd0;
	localparam logic [2:0] W_WAIT_AW = 3'd1;
	localparam logic [2:0] W_WAIT_W  = 3'd2;
	localparam logic [2:0] W_WAIT_B  = 3'd3;
	localparam logic [2:0] W_IDLE2   = 3'd4;

	logic [2:0] state;
	logic       final_beat;
	logic       issue;

	assign final_beat = !need_second || second_beat;
	assign issue      = (state == W_IDLE && start) || (state == W_IDLE2);

	always_ff @(posedge clock) begin
		if (reset) begin
			state       <= W_IDLE;
			mem_awvalid <= 1'b0;
			mem_wvalid  <= 1'b0;
			mem_bready  <= 1'b0;
			done        <= 1'b0;
			second_beat <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				W_WAIT_AW: begin
					if (mem_awready) begin
						mem_awvalid <= 1'b0;
						mem_wvalid  <= 1'b1;
						state       <= W_WAIT_W;
					end
				end
				W_WAIT_W: begin
					if (mem_wready) begin
						mem_wvalid <= 1'b0;
						mem_bready <= 1'b1;
						state      <= W_WAIT_B;
					end
				end
				W_WAIT_B: begin
					if (mem_bvalid) begin
						mem_bready <= 1'b0;
						if (final_beat) begin
							// single-beat store or second round finished
							done        <= 1'b1;
							second_beat <= 1'b0;
							state       <= W_IDLE;
						end else begin
							second_beat <= 1'b1;
							state       <= W_IDLE2;
						end
					end
				end
				default: begin
					if (issue) begin
						mem_awvalid <= 1'b1;
						state       <= W_WAIT_AW;
					end
				end
			endcase
		end
	end

	// beat payload captured when its address goes out
	always_ff @(posedge clock) begin
		if (issue) begin
			mem_awaddr <= awaddr;
			mem_wdata  <= wdata;
			mem_wstrb  <= wstrb;
		end
	end

	// every transfer is a single beat
	assign mem_wlast = mem_wvalid;

endmodule

`default_nettype wire

// ==== design/store_align.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_align #(
	parameter int ADDR_WIDTH = 32
) (
	input  lsu_pkg::mem_op_e               op,
	input  wire [ADDR_WIDTH-1:0]           addr,
	input  wire [31:0]                     store_data,
	input  wire                            second_beat,
	output logic                           need_second,
	output logic [ADDR_WIDTH-1:0]          awaddr,
	output logic [lsu_pkg::BEAT_WIDTH-1:0] wdata,
	output logic [lsu_pkg::STRB_WIDTH-1:0] wstrb
);

	localparam int PAIR_BYTES = 2 * lsu_pkg::STRB_WIDTH;
	localparam int PAIR_WIDTH = 2 * lsu_pkg::BEAT_WIDTH;
	localparam int OFS        = lsu_pkg::BEAT_OFFSET_BITS;

	logic [OFS-1:0]        offset;
	logic [3:0]            size_mask;
	logic [PAIR_BYTES-1:0] strb_pair;
	logic [PAIR_WIDTH-1:0] data_pair;
	logic [ADDR_WIDTH-1:0] low_addr;

	assign offset = addr[OFS-1:0];

	always_comb begin
		case (op)
			lsu_pkg::MEM_SW: size_mask = 4'b1111;
			lsu_pkg::MEM_SH: size_mask = 4'b0011;
			lsu_pkg::MEM_SB: size_mask = 4'b0001;
			default:         size_mask = 4'b0000;
		endcase
	end

	// two beats side by side, bytes past lane 7 spill into the upper one
	assign strb_pair = {{(PAIR_BYTES-4){1'b0}}, size_mask} << offset;
	assign data_pair = {{(PAIR_WIDTH-32){1'b0}}, store_data} << {offset, 3'b000};

	assign need_second = |strb_pair[PAIR_BYTES-1:lsu_pkg::STRB_WIDTH];

	assign wstrb = second_beat ? strb_pair[PAIR_BYTES-1:lsu_pkg::STRB_WIDTH] :
		strb_pair[lsu_pkg::STRB_WIDTH-1:0];
	assign wdata = second_beat ? data_pair[PAIR_WIDTH-1:lsu_pkg::BEAT_WIDTH] :
		data_pair[lsu_pkg::BEAT_WIDTH-1:0];

	assign low_addr = {addr[ADDR_WIDTH-1:OFS], {OFS{1'b0}}};
	assign awaddr   = second_beat ? low_addr + ADDR_WIDTH'(lsu_pkg::BEAT_BYTES) : low_addr;

endmodule

`default_nettype wire

// ==== test/lsu_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_checker #(
	parameter int ADDR_WIDTH = 32
) (
	input wire                           clock,
	input wire                           reset,
	input wire                           mem_arvalid,
	input wire                           mem_arready,
	input wire [ADDR_WIDTH-1:0]          mem_araddr,
	input wire                           mem_awvalid,
	input wire                           mem_awready,
	input wire [ADDR_WIDTH-1:0]          mem_awaddr,
	input wire                           mem_wvalid,
	input wire                           mem_wready,
	input wire [lsu_pkg::BEAT_WIDTH-1:0] mem_wdata,
	input wire [lsu_pkg::STRB_WIDTH-1:0] mem_wstrb,
	input wire                           mem_rready,
	input wire                           mem_bready,
	input wire                           in_valid,
	input wire                           retire,
	input wire                           in_allowin
);

	logic occupied;

	// stage occupancy seen from the instruction port alone
	always_ff @(posedge clock) begin
		if (reset) begin
			occupied <= 1'b0;
		end else if (in_valid && in_allowin) begin
			occupied <= 1'b1;
		end else if (retire) begin
			occupied <= 1'b0;
		end
	end

	// valid and payload hold until ready
	ar_stable: assert property (@(posedge clock) disable iff (reset)
		mem_arvalid && !mem_arready |=> mem_arvalid && $stable(mem_araddr))
		else $error("AR valid or address changed before ready");
	aw_stable: assert property (@(posedge clock) disable iff (reset)
		mem_awvalid && !mem_awready |=> mem_awvalid && $stable(mem_awaddr))
		else $error("AW valid or address changed before ready");
	w_stable: assert property (@(posedge clock) disable iff (reset)
		mem_wvalid && !mem_wready |=> mem_wvalid && $stable(mem_wdata) && $stable(mem_wstrb))
		else $error("W valid or payload changed before ready");

	readies_after_reset: assert property (@(posedge clock)
		$past(reset) |-> !mem_rready && !mem_bready)
		else $error("rready or bready high right after reset");

	// nothing retires from an empty stage
	retire_held: assert property (@(posedge clock) disable iff (reset)
		retire |-> occupied)
		else $error("retire with no instruction in the stage");

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter realtime PERIOD = 8.0
) (
	output logic clock
);

	initial begin
		clock = 1'b0;
	end

	always #(PERIOD / 2.0) clock = ~clock;

endmodule

`default_nettype wire

// ==== test/tb_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_lsu;

	localparam int N_OPS          = 128;
	localparam int TIMEOUT_CYCLES = N_OPS * 40 + 20;

	wire clock;
	logic reset;
	logic in_valid;
	lsu_pkg::mem_op_e in_op;
	logic [31:0] in_base;
	logic [31:0] in_offset;
	logic [31:0] in_store_data;
	logic [4:0] in_rd;
	wire in_allowin;
	wire retire;
	wire regfile_wen;
	wire [4:0] regfile_waddr;
	wire [31:0] regfile_wdata;
	wire mem_arvalid;
	wire [31:0] mem_araddr;
	logic mem_arready;
	logic mem_rvalid;
	logic [lsu_pkg::BEAT_WIDTH-1:0] mem_rdata;
	wire mem_rready;
	wire mem_awvalid;
	wire [31:0] mem_awaddr;
	logic mem_awready;
	wire mem_wvalid;
	wire [lsu_pkg::BEAT_WIDTH-1:0] mem_wdata;
	wire [lsu_pkg::STRB_WIDTH-1:0] mem_wstrb;
	wire mem_wlast;
	logic mem_wready;
	logic mem_bvalid;
	wire mem_bready;

	integer seed = 32'h21d8_1f1d;
	logic [7:0] mem [256];
	logic [7:0] shadow [256];
	logic [31:0] ar_log[$];
	logic [31:0] aw_log[$];
	logic [lsu_pkg::STRB_WIDTH-1:0] strb_log[$];
	logic [lsu_pkg::BEAT_WIDTH-1:0] wdata_log[$];
	logic [31:0] exp_wdata[$];
	logic [4:0] exp_waddr[$];
	int accepted = 0;
	int retired = 0;
	int op_count = 0;

	tb_clock #(.PERIOD(8.0)) i_clock (.clock(clock));

	lsu_top #(.ADDR_WIDTH(32), .REG_ADDR_WIDTH(5)) i_dut (.*);

	bind lsu_top lsu_checker #(.ADDR_WIDTH(ADDR_WIDTH)) i_checker (
		.clock(clock), .reset(reset), .mem_arvalid(mem_arvalid), .mem_arready(mem_arready),
		.mem_araddr(mem_araddr), .mem_awvalid(mem_awvalid), .mem_awready(mem_awready),
		.mem_awaddr(mem_awaddr), .mem_wvalid(mem_wvalid), .mem_wready(mem_wready),
		.mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb), .mem_rready(mem_rready),
		.mem_bready(mem_bready), .in_valid(in_valid), .retire(retire),
		.in_allowin(in_allowin)
	);

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic compare_data(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic compare_strb(input string what, input logic [lsu_pkg::STRB_WIDTH-1:0] got,
			input logic [lsu_pkg::STRB_WIDTH-1:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp));
		end
	endtask

	function automatic int op_size(input lsu_pkg::mem_op_e op);
		case (op)
			lsu_pkg::MEM_LW, lsu_pkg::MEM_SW: return 4;
			lsu_pkg::MEM_LH, lsu_pkg::MEM_LHU, lsu_pkg::MEM_SH: return 2;
			default: return 1;
		endcase
	endfunction

	// expected load value from the shadow bytes
	function automatic logic [31:0] ref_load(input logic [7:0] addr, input lsu_pkg::mem_op_e op);
		logic [31:0] raw;
		raw = 32'h0;
		for (int k = 0; k < op_size(op); k++) begin
			raw[8*k +: 8] = shadow[8'(addr + k)];
		end
		case (op)
			lsu_pkg::MEM_LH: return {{16{raw[15]}}, raw[15:0]};
			lsu_pkg::MEM_LB: return {{24{raw[7]}}, raw[7:0]};
			default: return raw;
		endcase
	endfunction

	function automatic logic [7:0] expected_strb(input int addr, input int size, input int beat);
		logic [7:0] s;
		s = 8'h0;
		for (int j = 0; j < 8; j++) begin
			s[j] = (beat + j >= addr) && (beat + j < addr + size);
		end
		return s;
	endfunction

	// memory read side: AR then one R beat
	initial begin
		logic [31:0] a;
		forever begin
			@(negedge clock);
			if (mem_arvalid && !reset) begin
				a = mem_araddr;
				@(posedge clock);
				repeat ($unsigned($random(seed)) % 4) @(posedge clock);
				mem_arready <= 1'b1;
				@(posedge clock);
				mem_arready <= 1'b0;
				ar_log.push_back(a);
				repeat ($unsigned($random(seed)) % 4) @(posedge clock);
				mem_rvalid <= 1'b1;
				for (int j = 0; j < 8; j++) begin
					mem_rdata[8*j +: 8] <= mem[8'(a + j)];
				end
				do @(negedge clock); while (!mem_rready);
				@(posedge clock);
				mem_rvalid <= 1'b0;
			end
		end
	end

	// memory write side: AW, W and B
	initial begin
		logic [31:0] a;
		forever begin
			@(negedge clock);
			if (mem_awvalid && !reset) begin
				a = mem_awaddr;
				@(posedge clock);
				repeat ($unsigned($random(seed)) % 4) @(posedge clock);
				mem_awready <= 1'b1;
				@(posedge clock);
				mem_awready <= 1'b0;
				do @(negedge clock); while (!mem_wvalid);
				repeat ($unsigned($random(seed)) % 4) @(negedge clock);
				aw_log.push_back(a);
				strb_log.push_back(mem_wstrb);
				wdata_log.push_back(mem_wdata);
				// each write beat is its own last beat
				compare_data("mem_wlast", 32'(mem_wlast), 32'd1);
				for (int j = 0; j < 8; j++) begin
					if (mem_wstrb[j]) begin
						mem[8'(a + j)] = mem_wdata[8*j +: 8];
					end
				end
				@(posedge clock);
				mem_wready <= 1'b1;
				@(posedge clock);
				mem_wready <= 1'b0;
				repeat ($unsigned($random(seed)) % 4) @(posedge clock);
				mem_bvalid <= 1'b1;
				do @(negedge clock); while (!mem_bready);
				@(posedge clock);
				mem_bvalid <= 1'b0;
			end
		end
	end

	// writeback compare and stage occupancy
	always @(negedge clock) begin
		if (!reset) begin
			if (accepted > retired && !retire && in_allowin) begin
				stop_on_error("in_allowin high while an instruction is still held");
			end
			if (regfile_wen) begin
				if (exp_wdata.size() == 0) begin
					stop_on_error("register write with no load outstanding");
				end
				compare_data("regfile_waddr", 32'(regfile_waddr), 32'(exp_waddr.pop_front()));
				compare_data("regfile_wdata", regfile_wdata, exp_wdata.pop_front());
			end
			if (retire) begin
				retired++;
				if (retired > accepted) begin
					stop_on_error("retire without an accepted instruction");
				end
			end
		end
	end

	task automatic run_op(input lsu_pkg::mem_op_e op, input logic [7:0] addr,
			input logic [31:0] data);
		int size;
		int nbeats;
		logic is_store;
		logic [7:0] low;
		logic [31:0] ofs;
		logic [4:0] rd;
		size    = op_size(op);
		is_store = op inside {lsu_pkg::MEM_SW, lsu_pkg::MEM_SH, lsu_pkg::MEM_SB};
		low     = addr & 8'hf8;
		nbeats  = ((addr & 7) + size > 8) ? 2 : 1;
		rd      = 5'(op_count);
		ofs     = $unsigned($random(seed)) & 32'h3f;
		ar_log.delete();
		aw_log.delete();
		strb_log.delete();
		wdata_log.delete();
		if (!is_store) begin
			exp_wdata.push_back(ref_load(addr, op));
			exp_waddr.push_back(rd);
		end
		@(posedge clock);
		in_valid      <= 1'b1;
		in_op         <= op;
		in_base       <= 32'(addr) - ofs;
		in_offset     <= ofs;
		in_store_data <= data;
		in_rd         <= rd;
		do @(negedge clock); while (!in_allowin);
		@(posedge clock);
		in_valid <= 1'b0;
		accepted++;
		do @(negedge clock); while (!retire);
		if (is_store) begin
			compare_data("write beat count", aw_log.size(), nbeats);
			for (int b = 0; b < nbeats; b++) begin
				compare_data("awaddr", aw_log[b], 32'(low) + 32'(8 * b));
				compare_strb("wstrb", strb_log[b], expected_strb(addr, size, low + 8 * b));
				for (int j = 0; j < 8; j++) begin
					if (strb_log[b][j]) begin
						compare_data("wdata lane", 32'(wdata_log[b][8*j +: 8]),
							32'(data[8*(low + 8*b + j - addr) +: 8]));
					end
				end
			end
			for (int k = 0; k < size; k++) begin
				shadow[8'(addr + k)] = data[8*k +: 8];
			end
		end else begin
			compare_data("read beat count", ar_log.size(), nbeats);
			for (int b = 0; b < nbeats; b++) begin
				compare_data("araddr", ar_log[b], 32'(low) + 32'(8 * b));
			end
		end
		op_count++;
	endtask

	initial begin
		lsu_pkg::mem_op_e loads[5];
		lsu_pkg::mem_op_e stores[3];
		lsu_pkg::mem_op_e readback[3];
		lsu_pkg::mem_op_e all_ops[8];
		logic [7:0] a;
		loads    = '{lsu_pkg::MEM_LW, lsu_pkg::MEM_LH, lsu_pkg::MEM_LHU, lsu_pkg::MEM_LB,
			lsu_pkg::MEM_LBU};
		stores   = '{lsu_pkg::MEM_SW, lsu_pkg::MEM_SH, lsu_pkg::MEM_SB};
		readback = '{lsu_pkg::MEM_LW, lsu_pkg::MEM_LHU, lsu_pkg::MEM_LBU};
		all_ops  = '{lsu_pkg::MEM_LW, lsu_pkg::MEM_LH, lsu_pkg::MEM_LHU, lsu_pkg::MEM_LB,
			lsu_pkg::MEM_LBU, lsu_pkg::MEM_SW, lsu_pkg::MEM_SH, lsu_pkg::MEM_SB};
		for (int i = 0; i < 256; i++) begin
			mem[i]    = 8'((i * 37 + 11) ^ (i >> 3));
			shadow[i] = mem[i];
		end
		reset         = 1'b1;
		in_valid      = 1'b0;
		in_op         = lsu_pkg::MEM_LW;
		in_base       = 32'h0;
		in_offset     = 32'h0;
		in_store_data = 32'h0;
		in_rd         = 5'h0;
		mem_arready   = 1'b0;
		mem_rvalid    = 1'b0;
		mem_rdata     = '0;
		mem_awready   = 1'b0;
		mem_wready    = 1'b0;
		mem_bvalid    = 1'b0;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		// idle outputs until the first instruction
		repeat (3) begin
			@(negedge clock);
			compare_data("in_allowin after reset", 32'(in_allowin), 32'd1);
			compare_data("outputs after reset", 32'({retire, regfile_wen, mem_arvalid,
				mem_awvalid, mem_wvalid, mem_rready, mem_bready}), 32'd0);
		end
		// every load type at every offset, crossing ones included
		for (int o = 0; o < 5; o++) begin
			for (int k = 0; k < 8; k++) begin
				run_op(loads[o], 8'(8'h20 + 8 * o + k), 32'h0);
			end
		end
		// stores at every offset, each read back
		for (int o = 0; o < 3; o++) begin
			for (int k = 0; k < 8; k++) begin
				a = 8'(8'h60 + 16 * o + k);
				run_op(stores[o], a, $random(seed));
				run_op(readback[o], a, 32'h0);
			end
		end
		// mixed traffic
		while (op_count < N_OPS) begin
			a = 8'(($unsigned($random(seed)) % 30) * 8 + ($unsigned($random(seed)) % 8));
			run_op(all_ops[$unsigned($random(seed)) % 8], a, $random(seed));
		end
		repeat (4) @(posedge clock);
		if (accepted == N_OPS && retired == N_OPS && exp_wdata.size() == 0) begin
			$display("TEST PASSED");
			$finish;
		end else begin
			stop_on_error($sformatf("accepted %0d and retired %0d of %0d instructions",
				accepted, retired, N_OPS));
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clock);
		stop_on_error("watchdog expired before all instructions retired");
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/lsu_pkg.sv
design/store_align.sv
design/load_align.sv
design/mem_read_ctrl.sv
design/mem_write_ctrl.sv
design/lsu_stage.sv
design/lsu_top.sv
test/tb_clock.sv
test/lsu_checker.sv
test/tb_lsu.sv
